// File: Makefile
# Verilator flow for the SPI bridge: build and run, lint, clean
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= spi_bridge_tb
RTL_TOP   ?= spi_bridge_top
FLIST     ?= spi_bridge_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
RTL_SRCS  ?= source/spi_bridge_pkg.sv source/credit_fifo.sv source/spi_slave_lane.sv \
             source/tx_dispatch.sv source/rx_collect.sv source/spi_bridge_top.sv
PASS_MSG  := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall -Isource --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/credit_fifo.sv
// ------------------------------------------------------------------
// Small synchronous FIFO for credit-based links. The sender's
// credits bound the fill level, so there is no full flag.
// ------------------------------------------------------------------

module credit_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 2
) (
    input  logic  aclk,
    input  logic  SS_s,
    input  logic  push,
    input  item_t push_item,
    input  logic  pop,
    output item_t head,
    output logic  not_empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    item_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge aclk or posedge SS_s) begin
        if (SS_s) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

endmodule

// File: source/rx_collect.sv
// ------------------------------------------------------------------
// Receive collector. One credit FIFO per lane, merged round-robin
// into the host stream with the lane tag. Each pop returns a
// credit to its lane.
// ------------------------------------------------------------------

`include "spi_bridge_cfg.svh"

module rx_collect (
    input  logic                       aclk,
    input  logic                       SS_s,
    input  logic [`SPI_LANES-1:0]      lane_rx_valid,
    input  spi_bridge_pkg::word_t      lane_rx_data [`SPI_LANES],
    output logic [`SPI_LANES-1:0]      lane_rx_credit,
    output logic                       rx_valid,
    output spi_bridge_pkg::host_word_t rx_word,
    input  logic                       rx_credit
);

    localparam int LANES   = `SPI_LANES;
    localparam int CREDITS = `SPI_CREDITS;
    localparam int CW      = $clog2(CREDITS + 1);

    spi_bridge_pkg::word_t fifo_head [LANES];
    logic [LANES-1:0]      fifo_ne;
    logic [LANES-1:0]      fifo_pop;
    spi_bridge_pkg::lane_t last;
    spi_bridge_pkg::lane_t pick;
    logic                  found;
    logic                  serve;
    logic [CW-1:0]         host_credits;

    for (genvar k = 0; k < LANES; k++) begin : fifo_g
        credit_fifo #(
            .item_t (spi_bridge_pkg::word_t),
            .DEPTH  (CREDITS)
        ) fifo_i (
            .aclk      (aclk),
            .SS_s      (SS_s),
            .push      (lane_rx_valid[k]),
            .push_item (lane_rx_data[k]),
            .pop       (fifo_pop[k]),
            .head      (fifo_head[k]),
            .not_empty (fifo_ne[k])
        );
    end

    // Search starts one past the lane served last
    always_comb begin
        int idx;
        found    = 1'b0;
        pick     = last;
        fifo_pop = '0;
        for (int i = 1; i <= LANES; i++) begin
            idx = (int'(last) + i) % LANES;
            if (!found && fifo_ne[idx]) begin
                found = 1'b1;
                pick  = spi_bridge_pkg::lane_t'(idx);
            end
        end
        serve = found && (host_credits != '0);
        if (serve) begin
            fifo_pop[pick] = 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (serve) begin
            rx_word.lane <= pick;
            rx_word.data <= fifo_head[pick];
        end
    end

    always_ff @(posedge aclk or posedge SS_s) begin
        if (SS_s) begin
            rx_valid       <= 1'b0;
            lane_rx_credit <= '0;
            last           <= spi_bridge_pkg::lane_t'(LANES - 1);
            host_credits   <= CW'(CREDITS);
        end else begin
            rx_valid       <= serve;
            lane_rx_credit <= fifo_pop;
            if (serve) begin
                last <= pick;
            end
            case ({serve, rx_credit})
                2'b10:   host_credits <= host_credits - 1'b1;
                2'b01:   host_credits <= host_credits + 1'b1;
                default: host_credits <= host_credits;
            endcase
        end
    end

endmodule

// File: source/spi_bridge_cfg.svh
// ------------------------------------------------------------------
// Build configuration of the multi-lane SPI slave bridge.
// Include this header wherever lane count, word width or credit
// depth are needed; the package pulls it in for its types.
// ------------------------------------------------------------------

`ifndef SPI_BRIDGE_CFG_SVH
`define SPI_BRIDGE_CFG_SVH

// Number of SPI slave lanes (2, 4 or 8)
`define SPI_LANES 4

// SPI word width in bits (8, 16 or 32)
`define SPI_WORD_W 8

// Credits per link, also the depth of every credit FIFO
`define SPI_CREDITS 2

`endif

// File: source/spi_bridge_pkg.sv
// ------------------------------------------------------------------
// Shared types of the SPI bridge. Host words carry the lane number
// next to the SPI word on both host streams.
// Refer to the types as spi_bridge_pkg::name.
// ------------------------------------------------------------------

package spi_bridge_pkg;

`include "spi_bridge_cfg.svh"

    // Lane index, sized from the lane count
    typedef logic [$clog2(`SPI_LANES)-1:0] lane_t;

    // One SPI word
    typedef logic [`SPI_WORD_W-1:0] word_t;

    // Host side word, lane tag in the upper bits
    typedef struct packed {
        lane_t lane;
        word_t data;
    } host_word_t;

endpackage

// File: source/spi_bridge_top.sv
// ------------------------------------------------------------------
// Multi-lane SPI slave bridge top. Host transmit words fan out
// through the dispatcher to the lanes; lane receive words merge
// in the collector. Per-lane SPI pins are bit vectors.
// ------------------------------------------------------------------

`include "spi_bridge_cfg.svh"

module spi_bridge_top (
    input  logic                       aclk,
    input  logic                       SS_s,
    input  logic                       tx_valid,
    input  spi_bridge_pkg::host_word_t tx_word,
    output logic                       tx_credit,
    output logic                       rx_valid,
    output spi_bridge_pkg::host_word_t rx_word,
    input  logic                       rx_credit,
    input  logic [`SPI_LANES-1:0]      spi_sck,
    input  logic [`SPI_LANES-1:0]      spi_cs,
    input  logic [`SPI_LANES-1:0]      spi_mosi,
    output logic [`SPI_LANES-1:0]      spi_miso,
    output logic [`SPI_LANES-1:0]      spi_miso_en
);

    localparam int LANES = `SPI_LANES;

    logic [LANES-1:0]      lane_tx_valid;
    logic [LANES-1:0]      lane_tx_credit;
    spi_bridge_pkg::word_t lane_tx_data;
    logic [LANES-1:0]      lane_rx_valid;
    logic [LANES-1:0]      lane_rx_credit;
    spi_bridge_pkg::word_t lane_rx_data [LANES];

    tx_dispatch dispatch_i (
        .aclk           (aclk),
        .SS_s           (SS_s),
        .tx_valid       (tx_valid),
        .tx_word        (tx_word),
        .tx_credit      (tx_credit),
        .lane_tx_valid  (lane_tx_valid),
        .lane_tx_data   (lane_tx_data),
        .lane_tx_credit (lane_tx_credit)
    );

    // Transmit data bus is shared, the valid bit selects the lane
    for (genvar k = 0; k < LANES; k++) begin : lane_g
        spi_slave_lane lane_i (
            .aclk        (aclk),
            .SS_s        (SS_s),
            .spi_sck     (spi_sck[k]),
            .spi_cs      (spi_cs[k]),
            .spi_mosi    (spi_mosi[k]),
            .spi_miso    (spi_miso[k]),
            .spi_miso_en (spi_miso_en[k]),
            .tx_valid    (lane_tx_valid[k]),
            .tx_data     (lane_tx_data),
            .tx_credit   (lane_tx_credit[k]),
            .rx_valid    (lane_rx_valid[k]),
            .rx_data     (lane_rx_data[k]),
            .rx_credit   (lane_rx_credit[k])
        );
    end

    rx_collect collect_i (
        .aclk           (aclk),
        .SS_s           (SS_s),
        .lane_rx_valid  (lane_rx_valid),
        .lane_rx_data   (lane_rx_data),
        .lane_rx_credit (lane_rx_credit),
        .rx_valid       (rx_valid),
        .rx_word        (rx_word),
        .rx_credit      (rx_credit)
    );

endmodule

// File: source/spi_slave_lane.sv
// ------------------------------------------------------------------
// One SPI slave lane. MOSI is sampled on falling SCK, MISO changes
// on rising SCK, MSB first. Word events cross into aclk through
// edge-detecting synchronizers; both aclk sides use credits.
// ------------------------------------------------------------------

`include "spi_bridge_cfg.svh"

module spi_slave_lane (
    input  logic                  aclk,
    input  logic                  SS_s,
    input  logic                  spi_sck,
    input  logic                  spi_cs,
    input  logic                  spi_mosi,
    output logic                  spi_miso,
    output logic                  spi_miso_en,
    input  logic                  tx_valid,
    input  spi_bridge_pkg::word_t tx_data,
    output logic                  tx_credit,
    output logic                  rx_valid,
    output spi_bridge_pkg::word_t rx_data,
    input  logic                  rx_credit
);

    localparam int W       = `SPI_WORD_W;
    localparam int BW      = $clog2(W);
    localparam int CREDITS = `SPI_CREDITS;
    localparam int CW      = $clog2(CREDITS + 1);

    logic                  sck_clr;
    logic [BW-1:0]         rx_bitcnt;
    logic [W-2:0]          rx_shift;
    spi_bridge_pkg::word_t rx_word_sck;
    logic                  rx_done;
    logic [BW-1:0]         tx_bitcnt;
    spi_bridge_pkg::word_t tx_shift;
    logic                  tx_load;

    logic [3:0]            done_sync;
    logic [3:0]            load_sync;
    logic                  done_evt;
    logic                  load_evt;
    spi_bridge_pkg::word_t fifo_head;
    logic                  fifo_ne;
    spi_bridge_pkg::word_t pend_data;
    logic                  pend;
    logic                  send;
    logic [CW-1:0]         rx_credits;

    // Deselect holds both bit counters at zero
    assign sck_clr     = spi_cs | SS_s;
    assign spi_miso_en = ~spi_cs;
    assign spi_miso    = tx_shift[W-1];

    // ------------------------------------------------------------------
    // SCK domain, receive on falling edge
    // ------------------------------------------------------------------
    always_ff @(negedge spi_sck or posedge sck_clr) begin
        if (sck_clr) begin
            rx_bitcnt <= '0;
        end else begin
            rx_bitcnt <= (rx_bitcnt == BW'(W - 1)) ? '0 : rx_bitcnt + 1'b1;
        end
    end

    always_ff @(negedge spi_sck) begin
        rx_shift <= {rx_shift[W-3:0], spi_mosi};
        if (rx_bitcnt == BW'(W - 1)) begin
            rx_word_sck <= {rx_shift, spi_mosi};
        end
    end

    // High for one SCK period after the last bit of a word
    always_ff @(negedge spi_sck or posedge SS_s) begin
        if (SS_s) begin
            rx_done <= 1'b0;
        end else begin
            rx_done <= (rx_bitcnt == BW'(W - 1));
        end
    end

    // ------------------------------------------------------------------
    // SCK domain, transmit on rising edge
    // ------------------------------------------------------------------
    always_ff @(posedge spi_sck or posedge sck_clr) begin
        if (sck_clr) begin
            tx_bitcnt <= '0;
        end else begin
            tx_bitcnt <= (tx_bitcnt == BW'(W - 1)) ? '0 : tx_bitcnt + 1'b1;
        end
    end

    // Word boundary loads the FIFO head, or zeros if nothing is queued
    always_ff @(posedge spi_sck) begin
        if (tx_bitcnt == '0) begin
            tx_shift <= fifo_ne ? fifo_head : '0;
        end else begin
            tx_shift <= {tx_shift[W-2:0], 1'b0};
        end
    end

    // Raised only when a queued word was actually taken
    always_ff @(posedge spi_sck or posedge SS_s) begin
        if (SS_s) begin
            tx_load <= 1'b0;
        end else begin
            tx_load <= (tx_bitcnt == '0) && fifo_ne;
        end
    end

    // ------------------------------------------------------------------
    // aclk domain
    // ------------------------------------------------------------------
    // Three sync stages plus one history bit for rising edge detect
    always_ff @(posedge aclk or posedge SS_s) begin
        if (SS_s) begin
            done_sync <= '0;
            load_sync <= '0;
        end else begin
            done_sync <= {done_sync[2:0], rx_done};
            load_sync <= {load_sync[2:0], tx_load};
        end
    end

    assign done_evt = done_sync[2] & ~done_sync[3];
    assign load_evt = load_sync[2] & ~load_sync[3];

    credit_fifo #(
        .item_t (spi_bridge_pkg::word_t),
        .DEPTH  (CREDITS)
    ) tx_fifo_i (
        .aclk      (aclk),
        .SS_s      (SS_s),
        .push      (tx_valid),
        .push_item (tx_data),
        .pop       (load_evt),
        .head      (fifo_head),
        .not_empty (fifo_ne)
    );

    // Pending word goes first; a new word straight through otherwise
    assign send = (pend || done_evt) && (rx_credits != '0);

    always_ff @(posedge aclk) begin
        if (send) begin
            rx_data <= pend ? pend_data : rx_word_sck;
        end
        if (done_evt && (!pend || send)) begin
            pend_data <= rx_word_sck;
        end
    end

    always_ff @(posedge aclk or posedge SS_s) begin
        if (SS_s) begin
            pend       <= 1'b0;
            rx_valid   <= 1'b0;
            tx_credit  <= 1'b0;
            rx_credits <= CW'(CREDITS);
        end else begin
            // A word arriving while one is stuck is dropped
            if (send) begin
                pend <= pend && done_evt;
            end else if (done_evt) begin
                pend <= 1'b1;
            end
            rx_valid  <= send;
            tx_credit <= load_evt;
            case ({send, rx_credit})
                2'b10:   rx_credits <= rx_credits - 1'b1;
                2'b01:   rx_credits <= rx_credits + 1'b1;
                default: rx_credits <= rx_credits;
            endcase
        end
    end

endmodule

// File: source/tx_dispatch.sv
// ------------------------------------------------------------------
// Transmit dispatcher. Routes host words to lanes by their lane
// tag and tracks one credit counter per lane. A word for a lane
// without credit waits in the holding register.
// ------------------------------------------------------------------

`include "spi_bridge_cfg.svh"

module tx_dispatch (
    input  logic                       aclk,
    input  logic                       SS_s,
    input  logic                       tx_valid,
    input  spi_bridge_pkg::host_word_t tx_word,
    output logic                       tx_credit,
    output logic [`SPI_LANES-1:0]      lane_tx_valid,
    output spi_bridge_pkg::word_t      lane_tx_data,
    input  logic [`SPI_LANES-1:0]      lane_tx_credit
);

    localparam int LANES   = `SPI_LANES;
    localparam int CREDITS = `SPI_CREDITS;
    localparam int CW      = $clog2(CREDITS + 1);

    logic [CW-1:0]              lane_credits [LANES];
    spi_bridge_pkg::host_word_t hold;
    spi_bridge_pkg::host_word_t sel;
    logic                       pend;
    logic                       fwd;
    logic [LANES-1:0]           spend;

    // Held word has priority over the host input
    always_comb begin
        sel   = pend ? hold : tx_word;
        fwd   = (pend || tx_valid) && (lane_credits[sel.lane] != '0);
        spend = '0;
        if (fwd) begin
            spend[sel.lane] = 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (tx_valid && (!pend || fwd)) begin
            hold <= tx_word;
        end
        if (fwd) begin
            lane_tx_data <= sel.data;
        end
    end

    always_ff @(posedge aclk or posedge SS_s) begin
        if (SS_s) begin
            pend          <= 1'b0;
            tx_credit     <= 1'b0;
            lane_tx_valid <= '0;
            for (int k = 0; k < LANES; k++) begin
                lane_credits[k] <= CW'(CREDITS);
            end
        end else begin
            pend          <= pend ? (!fwd || tx_valid) : (tx_valid && !fwd);
            // Host credit goes back with each forwarded word
            tx_credit     <= fwd;
            lane_tx_valid <= spend;
            for (int k = 0; k < LANES; k++) begin
                case ({spend[k], lane_tx_credit[k]})
                    2'b10:   lane_credits[k] <= lane_credits[k] - 1'b1;
                    2'b01:   lane_credits[k] <= lane_credits[k] + 1'b1;
                    default: lane_credits[k] <= lane_credits[k];
                endcase
            end
        end
    end

endmodule

// File: spi_bridge_top.f
+incdir+source
source/spi_bridge_pkg.sv
source/credit_fifo.sv
source/spi_slave_lane.sv
source/tx_dispatch.sv
source/rx_collect.sv
source/spi_bridge_top.sv
verification/spi_bridge_properties.sv
verification/spi_bridge_tb.sv

// File: verification/spi_bridge_properties.sv
// ------------------------------------------------------------------
// Credit and handshake checker for the SPI bridge, bound into the
// top level. Tracks outstanding items per link and flags any valid
// without a credit, any push into a full FIFO and stray lane tags.
// ------------------------------------------------------------------

`include "spi_bridge_cfg.svh"

module spi_bridge_properties (
    input logic                       aclk,
    input logic                       SS_s,
    input logic                       tx_valid,
    input logic                       tx_credit,
    input logic [`SPI_LANES-1:0]      lane_tx_valid,
    input logic [`SPI_LANES-1:0]      lane_tx_credit,
    input logic [`SPI_LANES-1:0]      lane_rx_valid,
    input logic [`SPI_LANES-1:0]      lane_rx_credit,
    input logic                       rx_valid,
    input spi_bridge_pkg::host_word_t rx_word,
    input logic                       rx_credit
);

    localparam int LANES   = `SPI_LANES;
    localparam int CREDITS = `SPI_CREDITS;

    // Items sent on each link and not yet credited back
    int out_tx;
    int out_rx;
    int out_ltx [LANES];
    int out_lrx [LANES];
    // Words waiting in the collector per lane
    int queued [LANES];
    int fails = 0;

    always_ff @(posedge aclk or posedge SS_s) begin
        if (SS_s) begin
            out_tx <= 0;
            out_rx <= 0;
            for (int k = 0; k < LANES; k++) begin
                out_ltx[k] <= 0;
                out_lrx[k] <= 0;
                queued[k]  <= 0;
            end
        end else begin
            out_tx <= out_tx + int'(tx_valid) - int'(tx_credit);
            out_rx <= out_rx + int'(rx_valid) - int'(rx_credit);
            for (int k = 0; k < LANES; k++) begin
                out_ltx[k] <= out_ltx[k] + int'(lane_tx_valid[k]) - int'(lane_tx_credit[k]);
                out_lrx[k] <= out_lrx[k] + int'(lane_rx_valid[k]) - int'(lane_rx_credit[k]);
                queued[k]  <= queued[k] + int'(lane_rx_valid[k])
                              - int'(rx_valid && (rx_word.lane == spi_bridge_pkg::lane_t'(k)));
            end
        end
    end

    a_tx_credit_held: assert property (@(posedge aclk) disable iff (SS_s)
        tx_valid |-> out_tx < CREDITS)
        else begin
            $error("transmit word accepted from host without a credit");
            fails++;
        end

    a_tx_credit_cap: assert property (@(posedge aclk) disable iff (SS_s)
        tx_credit |-> out_tx > 0)
        else begin
            $error("host transmit credits exceed the link depth");
            fails++;
        end

    a_rx_credit_held: assert property (@(posedge aclk) disable iff (SS_s)
        rx_valid |-> out_rx < CREDITS)
        else begin
            $error("receive word sent to host without a credit");
            fails++;
        end

    a_rx_credit_cap: assert property (@(posedge aclk) disable iff (SS_s)
        rx_credit |-> out_rx > 0)
        else begin
            $error("collector credit count toward host exceeds the link depth");
            fails++;
        end

    a_rx_lane_pending: assert property (@(posedge aclk) disable iff (SS_s)
        rx_valid |-> queued[rx_word.lane] > 0)
        else begin
            $error("rx_word tagged with a lane that had no pending word");
            fails++;
        end

    // Lane FIFOs and collector FIFOs hold CREDITS items each
    for (genvar k = 0; k < LANES; k++) begin : lane_g
        a_lane_tx_room: assert property (@(posedge aclk) disable iff (SS_s)
            lane_tx_valid[k] |-> out_ltx[k] < CREDITS)
            else begin
                $error("push into a full lane transmit FIFO");
                fails++;
            end

        a_lane_rx_room: assert property (@(posedge aclk) disable iff (SS_s)
            lane_rx_valid[k] |-> out_lrx[k] < CREDITS)
            else begin
                $error("push into a full collector FIFO");
                fails++;
            end
    end

endmodule

bind spi_bridge_top spi_bridge_properties props_i (
    .aclk           (aclk),
    .SS_s           (SS_s),
    .tx_valid       (tx_valid),
    .tx_credit      (tx_credit),
    .lane_tx_valid  (lane_tx_valid),
    .lane_tx_credit (lane_tx_credit),
    .lane_rx_valid  (lane_rx_valid),
    .lane_rx_credit (lane_rx_credit),
    .rx_valid       (rx_valid),
    .rx_word        (rx_word),
    .rx_credit      (rx_credit)
);

// File: verification/spi_bridge_tb.sv
// ------------------------------------------------------------------
// Testbench for the multi-lane SPI bridge. Acts as SPI master on
// every lane and as host on both credit streams; checks receive
// words, MISO data, merging, back-pressure and reset.
// ------------------------------------------------------------------

`include "spi_bridge_cfg.svh"

module spi_bridge_tb;

    localparam int LANES   = `SPI_LANES;
    localparam int W       = `SPI_WORD_W;
    localparam int CREDITS = `SPI_CREDITS;
    // Twice the length of six tests of two words per lane at ten aclk per bit
    localparam int LIMIT   = 2 * 6 * LANES * 2 * W * 10;

    logic                       aclk;
    logic                       SS_s;
    logic                       tx_valid;
    spi_bridge_pkg::host_word_t tx_word;
    logic                       tx_credit;
    logic                       rx_valid;
    spi_bridge_pkg::host_word_t rx_word;
    logic                       rx_credit;
    logic [LANES-1:0]           spi_sck;
    logic [LANES-1:0]           spi_cs;
    logic [LANES-1:0]           spi_mosi;
    logic [LANES-1:0]           spi_miso;
    logic [LANES-1:0]           spi_miso_en;

    integer                     seed = 28563;
    int                         errors = 0;
    int                         tests = 0;
    int                         cycles = 0;
    int                         tx_cred = CREDITS;
    int                         owed = 0;
    logic                       hold_rx = 1'b0;
    spi_bridge_pkg::host_word_t got_q [$];
    spi_bridge_pkg::word_t      exp_q [LANES][$];

    spi_bridge_top dut_i (
        .aclk        (aclk),
        .SS_s        (SS_s),
        .tx_valid    (tx_valid),
        .tx_word     (tx_word),
        .tx_credit   (tx_credit),
        .rx_valid    (rx_valid),
        .rx_word     (rx_word),
        .rx_credit   (rx_credit),
        .spi_sck     (spi_sck),
        .spi_cs      (spi_cs),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .spi_miso_en (spi_miso_en)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    initial begin
        while (cycles < LIMIT) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout: tests did not finish within %0d cycles", LIMIT);
        $display("** FAIL **");
        $finish;
    end

    // ------------------------------------------------------------------
    // Host model that collects receive words and returns credits
    // ------------------------------------------------------------------
    initial begin
        forever begin
            @(posedge aclk);
            #2;
            if (owed != 0 && !hold_rx) begin
                rx_credit = 1'b1;
                owed--;
            end else begin
                rx_credit = 1'b0;
            end
            @(negedge aclk);
            if (rx_valid) begin
                got_q.push_back(rx_word);
                owed++;
            end
            if (tx_credit) begin
                tx_cred++;
            end
            assert (tx_cred <= CREDITS) else begin
                $display("Dispatcher returned more transmit credits than the host spent");
                errors++;
            end
        end
    end

    // ------------------------------------------------------------------
    // Helper tasks
    // ------------------------------------------------------------------
    task automatic check_value(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got %0h expected %0h", sig, got, exp);
            errors++;
        end
    endtask

    function automatic int exp_total();
        int n;
        n = 0;
        for (int k = 0; k < LANES; k++) begin
            n += exp_q[k].size();
        end
        return n;
    endfunction

    task automatic half_sck();
        repeat (5) @(posedge aclk);
        #2;
    endtask

    task automatic random_words(output logic [LANES-1:0][W-1:0] w);
        for (int k = 0; k < LANES; k++) begin
            w[k] = W'($random(seed));
        end
    endtask

    task automatic apply_reset();
        @(posedge aclk);
        #2;
        SS_s = 1'b1;
        tx_cred = CREDITS;
        owed = 0;
        got_q.delete();
        for (int k = 0; k < LANES; k++) begin
            exp_q[k].delete();
        end
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        check_value("tx_credit", 32'(tx_credit), 0);
        check_value("rx_valid", 32'(rx_valid), 0);
        check_value("lane_tx_valid", 32'(dut_i.lane_tx_valid), 0);
        check_value("lane_rx_valid", 32'(dut_i.lane_rx_valid), 0);
        @(posedge aclk);
        #2;
        SS_s = 1'b0;
    endtask

    // One word on every selected lane with MOSI and MISO MSB first
    task automatic spi_xfer(input logic [LANES-1:0] sel,
                            input logic [LANES-1:0][W-1:0] mo,
                            output logic [LANES-1:0][W-1:0] mi);
        logic [LANES-1:0] en_exp;
        mi = '0;
        for (int k = 0; k < LANES; k++) begin
            if (sel[k]) begin
                exp_q[k].push_back(mo[k]);
            end
        end
        @(posedge aclk);
        #2;
        spi_cs = ~sel;
        en_exp = ~spi_cs;
        for (int b = W - 1; b >= 0; b--) begin
            half_sck();
            for (int k = 0; k < LANES; k++) begin
                spi_mosi[k] = mo[k][b];
            end
            spi_sck = sel;
            half_sck();
            // MISO moved on the rising edge and is taken at the falling one
            for (int k = 0; k < LANES; k++) begin
                mi[k][b] = spi_miso[k];
            end
            check_value("spi_miso_en", 32'(spi_miso_en), 32'(en_exp));
            spi_sck = '0;
        end
        half_sck();
        spi_cs = '1;
        half_sck();
        check_value("spi_miso_en", 32'(spi_miso_en), 0);
    endtask

    task automatic host_send(input spi_bridge_pkg::lane_t lane, input spi_bridge_pkg::word_t data);
        @(posedge aclk);
        while (tx_cred == 0) begin
            @(posedge aclk);
        end
        #2;
        tx_valid = 1'b1;
        tx_word.lane = lane;
        tx_word.data = data;
        tx_cred--;
        @(posedge aclk);
        #2;
        tx_valid = 1'b0;
    endtask

    // A returned host credit means the word left the dispatcher
    task automatic wait_tx_credits();
        while (tx_cred != CREDITS) begin
            @(posedge aclk);
        end
        repeat (4) @(posedge aclk);
    endtask

    // Waits for every expected word and then matches lanes and order
    task automatic drain_rx();
        spi_bridge_pkg::host_word_t hw;
        while (got_q.size() < exp_total()) begin
            @(posedge aclk);
        end
        repeat (20) @(posedge aclk);
        while (got_q.size() > 0) begin
            hw = got_q.pop_front();
            assert (exp_q[hw.lane].size() != 0) else begin
                $display("Word %0h arrived on lane %0d with nothing expected", hw.data, hw.lane);
                errors++;
            end
            if (exp_q[hw.lane].size() != 0) begin
                check_value($sformatf("rx_word.data lane %0d", hw.lane), 32'(hw.data),
                            32'(exp_q[hw.lane].pop_front()));
            end
        end
        assert (exp_total() == 0) else begin
            $display("%0d receive words never reached the host", exp_total());
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int e0);
        tests++;
        $display("Test %0d %-13s %0d errors", tests, name, errors - e0);
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        logic [LANES-1:0][W-1:0] mo;
        logic [LANES-1:0][W-1:0] mi;
        spi_bridge_pkg::word_t   tw;
        int                      e0;
        int                      total;
        SS_s      = 1'b1;
        tx_valid  = 1'b0;
        tx_word   = '0;
        rx_credit = 1'b0;
        spi_sck   = '0;
        spi_cs    = '1;
        spi_mosi  = '0;
        apply_reset();

        e0 = errors;
        for (int k = 0; k < LANES; k++) begin
            random_words(mo);
            spi_xfer(LANES'(1) << k, mo, mi);
        end
        drain_rx();
        end_test("receive", e0);

        e0 = errors;
        for (int k = 0; k < LANES; k++) begin
            tw = W'($random(seed));
            host_send(spi_bridge_pkg::lane_t'(k), tw);
            wait_tx_credits();
            random_words(mo);
            spi_xfer(LANES'(1) << k, mo, mi);
            check_value($sformatf("spi_miso lane %0d", k), 32'(mi[k]), 32'(tw));
        end
        drain_rx();
        end_test("transmit", e0);

        e0 = errors;
        random_words(mo);
        spi_xfer('1, mo, mi);
        for (int k = 0; k < LANES; k++) begin
            check_value($sformatf("spi_miso lane %0d", k), 32'(mi[k]), 0);
        end
        drain_rx();
        end_test("empty tx", e0);

        e0 = errors;
        repeat (2) begin
            random_words(mo);
            spi_xfer('1, mo, mi);
        end
        drain_rx();
        end_test("merge", e0);

        // With host credits withheld the lanes fill collector FIFOs and pend
        e0 = errors;
        hold_rx = 1'b1;
        repeat (3) begin
            random_words(mo);
            spi_xfer('1, mo, mi);
        end
        repeat (20) @(posedge aclk);
        assert (got_q.size() <= CREDITS) else begin
            $display("%0d words reached the host without credits", got_q.size());
            errors++;
        end
        hold_rx = 1'b0;
        drain_rx();
        end_test("backpressure", e0);

        // Lane 0 FIFO fills up and one more word stalls in the dispatcher
        e0 = errors;
        for (int i = 0; i <= CREDITS; i++) begin
            host_send('0, W'($random(seed)));
        end
        apply_reset();
        @(negedge aclk);
        check_value("tx_credit", 32'(tx_credit), 0);
        check_value("rx_valid", 32'(rx_valid), 0);
        for (int i = 0; i < CREDITS; i++) begin
            host_send('0, W'($random(seed)));
        end
        repeat (10) @(posedge aclk);
        check_value("host tx credits", 32'(tx_cred), 32'(CREDITS));
        end_test("reset", e0);

        total = errors + dut_i.props_i.fails;
        $display("Tests run %0d, failed checks %0d, bound assertion failures %0d",
                 tests, total, dut_i.props_i.fails);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
